// ==== verilog.f ====
+incdir+.
wb2sdrc_pkg.sv
sync_fifo.sv
wb_req_fsm.sv
wb2sdrc.sv
tb_wb2sdrc.sv

// ==== tb_wb2sdrc.sv ====
// Testbench for the Wishbone to SDRAM controller bridge
// Wishbone master tasks, a small SDRAM controller model with a memory,
// and rule-based checks on the acknowledge, the request level and the data

`timescale 1ns/100ps

`include "wb2sdrc_macros.svh"

module tb_wb2sdrc;

  import wb2sdrc_pkg::*;

  // ---------------------------------------------------------------------------
  // Run constants
  // ---------------------------------------------------------------------------
  localparam int CLK_HALF     = 10;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 3;
  // Full sequence needs well under 600 cycles, limit leaves a wide margin
  localparam int MAX_CYCLES   = 3000;
  localparam int RAND_PAIRS   = 24;
  localparam int MEM_WORDS    = 32;
  localparam int CMD_DEPTH    = `WB2SDRC_CMD_DEPTH;
  localparam int BEAT_DEPTH   = `WB2SDRC_WRDATA_DEPTH;

  // DUT ports
  logic       sdram_clk;
  logic       wb_clk_i;
  logic       wb_stb_i;
  logic       wb_cyc_i;
  logic       wb_we_i;
  app_addr_t  wb_addr_i;
  wb_data_t   wb_dat_i;
  byte_en_t   wb_sel_i;
  logic       wb_ack_o;
  wb_data_t   wb_dat_o;
  logic       sdr_req_o;
  app_addr_t  sdr_req_addr_o;
  logic       sdr_req_wr_n_o;
  burst_len_t sdr_req_len_o;
  logic       sdr_req_ack_i;
  wb_data_t   sdr_wr_data_o;
  byte_en_t   sdr_wr_en_n_o;
  logic       sdr_wr_next_i;
  logic       sdr_rd_valid_i;
  wb_data_t   sdr_rd_data_i;

  // Bookkeeping
  integer seed = 17122;
  int     errors = 0;
  int     cycles = 0;
  int     writes_done = 0;
  int     reads_done = 0;
  int     cmds_taken = 0;
  int     rd_cmds = 0;
  int     rd_hold = 0;
  logic   stall_ack = 1'b0;

  // Predicted memory contents and expected controller traffic
  wb_data_t     shadow_mem [MEM_WORDS];
  wb_data_t     model_mem [MEM_WORDS];
  sdr_cmd_t     exp_cmd_q [$];
  sdr_wr_beat_t exp_beat_q [$];

  // Expected FIFO levels and read tracking
  int   cmd_level;
  int   beat_level;
  int   rd_words;
  logic rd_out;
  logic wb_req;
  logic wr_push_exp;
  logic rd_push_exp;
  logic rd_ack_exp;
  logic ack_exp;

  wb2sdrc i_dut (.*);

  initial begin
    sdram_clk = 1'b0;
    forever #CLK_HALF sdram_clk = ~sdram_clk;
  end

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors = errors + 1;
    $display("error %s: got %0h expected %0h at %0t", name, got, exp, $time);
  endtask

  // Startup pattern, every address bit shows in every byte
  function automatic wb_data_t fill_word(input int idx);
    return (32'(idx) * 32'h0101_0101) ^ 32'h5ac3_3ca5;
  endfunction

  function automatic wb_data_t byte_merge(input wb_data_t old_word, input wb_data_t new_word,
                                          input byte_en_t sel);
    wb_data_t merged;
    merged = old_word;
    for (int b = 0; b < `WB2SDRC_SEL_W; b++) begin
      if (sel[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // ---------------------------------------------------------------------------
  // Expected behavior
  // ---------------------------------------------------------------------------
  assign wb_req      = wb_stb_i & wb_cyc_i;
  // Posted write needs room in both the command and the beat FIFO
  assign wr_push_exp = wb_req & wb_we_i & (cmd_level < CMD_DEPTH) & (beat_level < BEAT_DEPTH);
  // One command per read, issued before it is outstanding
  assign rd_push_exp = wb_req & ~wb_we_i & ~rd_out & (cmd_level < CMD_DEPTH);
  assign rd_ack_exp  = wb_req & ~wb_we_i & rd_out & (rd_words != 0);
  assign ack_exp     = wr_push_exp | rd_ack_exp;

  always @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      cmd_level  <= 0;
      beat_level <= 0;
      rd_words   <= 0;
      rd_out     <= 1'b0;
    end else begin
      cmd_level  <= cmd_level + int'(wr_push_exp | rd_push_exp) - int'(sdr_req_ack_i);
      beat_level <= beat_level + int'(wr_push_exp) - int'(sdr_wr_next_i);
      rd_words   <= rd_words + int'(sdr_rd_valid_i) - int'(rd_ack_exp);
      if (rd_push_exp) begin
        rd_out <= 1'b1;
        exp_cmd_q.push_back({1'b1, wb_addr_i});
      end else if (rd_ack_exp) begin
        rd_out <= 1'b0;
      end
      if (wr_push_exp) begin
        exp_cmd_q.push_back({1'b0, wb_addr_i});
        exp_beat_q.push_back({~wb_sel_i, wb_dat_i});
        shadow_mem[wb_addr_i[4:0]] <= byte_merge(shadow_mem[wb_addr_i[4:0]], wb_dat_i, wb_sel_i);
      end
    end
  end

  // Acknowledge follows the posting and read-return rules
  ack_rule: assert property (@(posedge sdram_clk) disable iff (wb_clk_i) wb_ack_o == ack_exp)
    else report_mismatch("wb_ack_o", $sampled(wb_ack_o), $sampled(ack_exp));

  // Request level mirrors the command backlog
  req_rule: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
                             sdr_req_o == (cmd_level != 0))
    else report_mismatch("sdr_req_o", $sampled(sdr_req_o), $sampled(cmd_level != 0));

  // ---------------------------------------------------------------------------
  // SDRAM controller model
  // ---------------------------------------------------------------------------
  initial begin : sdram_model
    sdr_cmd_t     cmd;
    sdr_wr_beat_t beat;
    logic [4:0]   rd_q [$];
    int           take_wait;
    int           rd_wait;
    take_wait = 0;
    rd_wait   = 0;
    @(negedge wb_clk_i);
    forever begin
      @(posedge sdram_clk);
      #DRIVE_DLY;
      sdr_req_ack_i  = 1'b0;
      sdr_wr_next_i  = 1'b0;
      sdr_rd_valid_i = 1'b0;
      // Oldest read returns once its delay runs out
      if (rd_q.size() != 0) begin
        if (rd_wait == 0) begin
          sdr_rd_valid_i = 1'b1;
          sdr_rd_data_i  = model_mem[rd_q.pop_front()];
          rd_wait        = {$random(seed)} % 4;
        end else begin
          rd_wait = rd_wait - 1;
        end
      end
      // Take the head command after a random wait, unless stalled
      if (sdr_req_o && !stall_ack) begin
        if (take_wait != 0) begin
          take_wait = take_wait - 1;
        end else begin
          sdr_req_ack_i = 1'b1;
          cmds_taken    = cmds_taken + 1;
          take_wait     = {$random(seed)} % 3;
          if (exp_cmd_q.size() == 0) begin
            errors = errors + 1;
            $display("command for address %0h arrived with no request behind it",
                     sdr_req_addr_o);
          end else begin
            cmd = exp_cmd_q.pop_front();
            assert (sdr_req_addr_o == cmd.addr)
              else report_mismatch("sdr_req_addr_o", sdr_req_addr_o, cmd.addr);
            assert (sdr_req_wr_n_o == cmd.wr_n)
              else report_mismatch("sdr_req_wr_n_o", sdr_req_wr_n_o, cmd.wr_n);
          end
          assert (sdr_req_len_o == 9'd1)
            else report_mismatch("sdr_req_len_o", sdr_req_len_o, 9'd1);
          if (!sdr_req_wr_n_o) begin
            // Matching beat is consumed with the write command
            sdr_wr_next_i = 1'b1;
            if (exp_beat_q.size() != 0) begin
              beat = exp_beat_q.pop_front();
              assert (sdr_wr_data_o == beat.data)
                else report_mismatch("sdr_wr_data_o", sdr_wr_data_o, beat.data);
              assert (sdr_wr_en_n_o == beat.en_n)
                else report_mismatch("sdr_wr_en_n_o", sdr_wr_en_n_o, beat.en_n);
            end else begin
              errors = errors + 1;
              $display("write command for address %0h came with no write beat expected",
                       sdr_req_addr_o);
            end
            model_mem[sdr_req_addr_o[4:0]] = byte_merge(model_mem[sdr_req_addr_o[4:0]],
                                                        sdr_wr_data_o, ~sdr_wr_en_n_o);
          end else begin
            rd_cmds = rd_cmds + 1;
            if (rd_q.size() == 0) begin
              rd_wait = {$random(seed)} % 4 + rd_hold;
            end
            rd_q.push_back(sdr_req_addr_o[4:0]);
          end
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Wishbone master
  // ---------------------------------------------------------------------------
  // Completes on the rising edge after ack is seen, data taken before it
  task automatic wait_for_ack(output wb_data_t data);
    @(negedge sdram_clk);
    while (!wb_ack_o) begin
      @(negedge sdram_clk);
    end
    data = wb_dat_o;
    @(posedge sdram_clk);
    #DRIVE_DLY;
  endtask

  task automatic wb_write(input app_addr_t addr, input wb_data_t data, input byte_en_t sel);
    wb_data_t unused;
    @(posedge sdram_clk);
    #DRIVE_DLY;
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = 1'b1;
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_sel_i  = sel;
    wait_for_ack(unused);
    wb_stb_i    = 1'b0;
    wb_cyc_i    = 1'b0;
    wb_we_i     = 1'b0;
    writes_done = writes_done + 1;
  endtask

  task automatic wb_read(input app_addr_t addr);
    wb_data_t data;
    @(posedge sdram_clk);
    #DRIVE_DLY;
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = 1'b0;
    wb_addr_i = addr;
    wait_for_ack(data);
    wb_stb_i   = 1'b0;
    wb_cyc_i   = 1'b0;
    reads_done = reads_done + 1;
    assert (data == shadow_mem[addr[4:0]])
      else report_mismatch("wb_dat_o", data, shadow_mem[addr[4:0]]);
  endtask

  task automatic wait_idle();
    while (exp_cmd_q.size() != 0) begin
      @(posedge sdram_clk);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  initial begin : stimulus
    app_addr_t rand_addr [RAND_PAIRS];
    wb_data_t  rand_data [RAND_PAIRS];
    byte_en_t  rand_sel [RAND_PAIRS];
    int        cmds_before;
    wb_clk_i       = 1'b1;
    wb_stb_i       = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_addr_i      = '0;
    wb_dat_i       = '0;
    wb_sel_i       = '0;
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow_mem[i] = fill_word(i);
      model_mem[i]  = fill_word(i);
    end
    // Random pairs drawn before the controller model starts using the seed
    for (int n = 0; n < RAND_PAIRS; n++) begin
      rand_addr[n] = app_addr_t'($random(seed));
      rand_data[n] = wb_data_t'($random(seed));
      rand_sel[n]  = byte_en_t'($random(seed));
    end
    repeat (RESET_CYCLES) @(posedge sdram_clk);
    #DRIVE_DLY;
    wb_clk_i = 1'b0;
    // Quiet stretch after reset
    repeat (5) @(posedge sdram_clk);

    // Single writes, full and partial selects
    wb_write(26'h000_0003, 32'hdead_beef, 4'hf);
    wb_write(26'h123_4567, 32'h0bad_f00d, 4'h5);
    wait_idle();

    // Long-held reads, one written and one at the fill pattern
    rd_hold     = 15;
    cmds_before = rd_cmds;
    wb_read(26'h000_0003);
    wb_read(26'h000_0011);
    rd_hold = 0;
    if (rd_cmds != cmds_before + 2) begin
      errors = errors + 1;
      $display("two held reads produced %0d read commands", rd_cmds - cmds_before);
    end
    wait_idle();

    // Stalled controller, command FIFO fills and the fifth write waits
    stall_ack = 1'b1;
    for (int i = 0; i < CMD_DEPTH; i++) begin
      wb_write(26'h000_0040 + i, 32'h1111_1111 * (i + 1), 4'hf);
    end
    fork
      wb_write(26'h000_0044, 32'h5555_5555, 4'hf);
      begin
        repeat (12) @(posedge sdram_clk);
        stall_ack = 1'b0;
      end
    join
    wait_idle();

    // Random write then read-back of the same address
    for (int n = 0; n < RAND_PAIRS; n++) begin
      wb_write(rand_addr[n], rand_data[n], rand_sel[n]);
      wb_read(rand_addr[n]);
    end
    wait_idle();
    repeat (4) @(posedge sdram_clk);
    if (exp_beat_q.size() != 0) begin
      errors = errors + 1;
      $display("%0d write beats were never consumed", exp_beat_q.size());
    end

    $display("summary: %0d errors, %0d writes, %0d reads, %0d commands taken",
             errors, writes_done, reads_done, cmds_taken);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Cycle limit
  always @(posedge sdram_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped at %0d cycles before the tests finished", cycles);
      $display("test failed");
      $finish;
    end
  end

endmodule

// ==== wb2sdrc.sv ====
// Wishbone slave to SDRAM controller request bridge
// Commands, write beats and read data pass through synchronous FIFOs
// Single clock domain, burst length fixed at one transfer

`timescale 1ns/100ps

`include "wb2sdrc_macros.svh"

module wb2sdrc (
  input  logic                      sdram_clk,
  input  logic                      wb_clk_i,

  // Wishbone slave
  input  logic                      wb_stb_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_we_i,
  input  wb2sdrc_pkg::app_addr_t    wb_addr_i,
  input  wb2sdrc_pkg::wb_data_t     wb_dat_i,
  input  wb2sdrc_pkg::byte_en_t     wb_sel_i,
  output logic                      wb_ack_o,
  output wb2sdrc_pkg::wb_data_t     wb_dat_o,

  // SDRAM controller request side
  output logic                      sdr_req_o,
  output wb2sdrc_pkg::app_addr_t    sdr_req_addr_o,
  output logic                      sdr_req_wr_n_o,
  output wb2sdrc_pkg::burst_len_t   sdr_req_len_o,
  input  logic                      sdr_req_ack_i,
  output wb2sdrc_pkg::wb_data_t     sdr_wr_data_o,
  output wb2sdrc_pkg::byte_en_t     sdr_wr_en_n_o,
  input  logic                      sdr_wr_next_i,
  input  logic                      sdr_rd_valid_i,
  input  wb2sdrc_pkg::wb_data_t     sdr_rd_data_i
);

  import wb2sdrc_pkg::*;

  // FIFO strobes from the request controller
  logic cmd_push;
  logic wrdata_push;
  logic rddata_pop;

  // FIFO status
  logic cmd_full;
  logic cmd_empty;
  logic wrdata_full;
  logic rddata_empty;

  // Packed FIFO payloads
  sdr_cmd_t     cmd_in;
  sdr_cmd_t     cmd_head;
  sdr_wr_beat_t beat_in;
  sdr_wr_beat_t beat_head;

  // ---------------------------------------------------------------------------
  // Request controller
  // ---------------------------------------------------------------------------
  wb_req_fsm u_req_fsm (
    .sdram_clk      (sdram_clk),
    .wb_clk_i       (wb_clk_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .cmd_full_i     (cmd_full),
    .wrdata_full_i  (wrdata_full),
    .rddata_empty_i (rddata_empty),
    .wb_ack_o       (wb_ack_o),
    .cmd_push_o     (cmd_push),
    .wrdata_push_o  (wrdata_push),
    .rddata_pop_o   (rddata_pop)
  );

  // ---------------------------------------------------------------------------
  // Command path
  // ---------------------------------------------------------------------------
  // Write flag is active low on the controller side
  assign cmd_in.wr_n = ~wb_we_i;
  assign cmd_in.addr = wb_addr_i;

  // Popped when the controller takes the request
  sync_fifo #(
    .WIDTH ($bits(sdr_cmd_t)),
    .DEPTH (`WB2SDRC_CMD_DEPTH)
  ) u_cmd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push),
    .push_data_i (cmd_in),
    .pop_i       (sdr_req_ack_i),
    .pop_data_o  (cmd_head),
    .full_o      (cmd_full),
    .empty_o     (cmd_empty)
  );

  // Request level while a command waits
  assign sdr_req_o      = ~cmd_empty;
  assign sdr_req_addr_o = cmd_head.addr;
  assign sdr_req_wr_n_o = cmd_head.wr_n;
  // Fixed single-transfer burst
  assign sdr_req_len_o  = burst_len_t'(`WB2SDRC_BURST_LEN);

  // ---------------------------------------------------------------------------
  // Write data path
  // ---------------------------------------------------------------------------
  // Selects become active-low byte enables
  assign beat_in.en_n = ~wb_sel_i;
  assign beat_in.data = wb_dat_i;

  // Empty flag not needed, controller only asks for beats it was promised
  sync_fifo #(
    .WIDTH ($bits(sdr_wr_beat_t)),
    .DEPTH (`WB2SDRC_WRDATA_DEPTH)
  ) u_wrdata_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wrdata_push),
    .push_data_i (beat_in),
    .pop_i       (sdr_wr_next_i),
    .pop_data_o  (beat_head),
    .full_o      (wrdata_full),
    .empty_o     ()
  );

  assign sdr_wr_data_o = beat_head.data;
  assign sdr_wr_en_n_o = beat_head.en_n;

  // ---------------------------------------------------------------------------
  // Read data path
  // ---------------------------------------------------------------------------
  // Never overfills, at most one read outstanding
  sync_fifo #(
    .WIDTH ($bits(wb_data_t)),
    .DEPTH (`WB2SDRC_RDDATA_DEPTH)
  ) u_rddata_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .pop_i       (rddata_pop),
    .pop_data_o  (wb_dat_o),
    .full_o      (),
    .empty_o     (rddata_empty)
  );

endmodule

// ==== wb_req_fsm.sv ====
// Wishbone request controller for the SDRAM bridge
// Generates the acknowledge and FIFO strobes, tracks one outstanding read

`timescale 1ns/100ps

module wb_req_fsm (
  input  logic sdram_clk,
  input  logic wb_clk_i,

  // Wishbone request
  input  logic wb_stb_i,
  input  logic wb_cyc_i,
  input  logic wb_we_i,

  // FIFO status
  input  logic cmd_full_i,
  input  logic wrdata_full_i,
  input  logic rddata_empty_i,

  // Acknowledge and FIFO strobes
  output logic wb_ack_o,
  output logic cmd_push_o,
  output logic wrdata_push_o,
  output logic rddata_pop_o
);

  import wb2sdrc_pkg::*;

  // Request decode
  logic wb_req;
  logic wr_req;
  logic rd_req;

  // Per-direction acknowledge
  logic wr_ack;
  logic rd_ack;

  // Read command issue
  logic rd_cmd_push;

  // Read tracking FSM
  rd_state_e rd_state;
  rd_state_e rd_state_nxt;

  // ---------------------------------------------------------------------------
  // Request decode
  // ---------------------------------------------------------------------------
  // Active while strobe and cycle both high
  assign wb_req = wb_stb_i & wb_cyc_i;
  assign wr_req = wb_req & wb_we_i;
  assign rd_req = wb_req & ~wb_we_i;

  // ---------------------------------------------------------------------------
  // Acknowledge
  // ---------------------------------------------------------------------------
  // Write is posted, needs room for command and beat
  assign wr_ack = wr_req & ~cmd_full_i & ~wrdata_full_i;

  // Read waits for its data word in the read FIFO
  assign rd_ack = rd_req & (rd_state == RD_WAIT) & ~rddata_empty_i;

  // Same-cycle acknowledge, combinational
  assign wb_ack_o = wr_ack | rd_ack;

  // ---------------------------------------------------------------------------
  // FIFO strobes
  // ---------------------------------------------------------------------------
  // One command per read, only before it is outstanding
  assign rd_cmd_push = rd_req & (rd_state == RD_IDLE) & ~cmd_full_i;

  // Write command goes with its acknowledge
  assign cmd_push_o = wr_ack | rd_cmd_push;

  // Beat pushed alongside the write command
  assign wrdata_push_o = wr_ack;

  // Read word consumed as it is acknowledged
  assign rddata_pop_o = rd_ack;

  // ---------------------------------------------------------------------------
  // Read tracking
  // ---------------------------------------------------------------------------
  // Set on the read command push, not on the request, so that a read
  // arriving right behind back-to-back writes is tracked from the edge
  // its command really enters the FIFO
  always_comb begin
    rd_state_nxt = rd_state;
    unique case (rd_state)
      RD_IDLE: begin
        if (rd_cmd_push) begin
          rd_state_nxt = RD_WAIT;
        end
      end
      RD_WAIT: begin
        // Data handed over, next read may issue
        if (rd_ack) begin
          rd_state_nxt = RD_IDLE;
        end
      end
      default: rd_state_nxt = RD_IDLE;
    endcase
  end

  // State register
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

endmodule

// ==== sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO
// Head entry is always on pop_data_o, flags derived from an occupancy count

`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             sdram_clk,
  input  logic             wb_clk_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] pop_data_o,
  output logic             full_o,
  output logic             empty_o
);

  // ---------------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------------
  // Pointer indexes the array, count must also hold DEPTH itself
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Last valid index, pointers wrap after it
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

  // Storage
  logic [WIDTH-1:0] mem [DEPTH];

  // Control state
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Qualified strobes
  logic wr_en;
  logic rd_en;

  // ---------------------------------------------------------------------------
  // Strobe qualification
  // ---------------------------------------------------------------------------
  // Push into a full FIFO is dropped
  assign wr_en = push_i & ~full_o;
  // Pop from an empty FIFO is ignored
  assign rd_en = pop_i & ~empty_o;

  // Flags straight from the count
  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

  // Head entry, visible without a pop
  assign pop_data_o = mem[rd_ptr];

  // ---------------------------------------------------------------------------
  // Storage write
  // ---------------------------------------------------------------------------
  always_ff @(posedge sdram_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // ---------------------------------------------------------------------------
  // Pointers
  // ---------------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      // Write side, wraps at the last entry
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      // Read side, head advances on the popping edge
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Occupancy
  // ---------------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      count <= '0;
    end else begin
      unique case ({wr_en, rd_en})
        // Push only
        2'b10: count <= count + 1'b1;
        // Pop only
        2'b01: count <= count - 1'b1;
        // Both or neither, level unchanged
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== wb2sdrc_pkg.sv ====
// Wishbone to SDRAM controller bridge types
// Vector types, the command and write-beat structs and the read FSM states

`include "wb2sdrc_macros.svh"

package wb2sdrc_pkg;

  // -------------------------------------------------------------------------
  // Plain vectors
  // -------------------------------------------------------------------------
  // Address as seen by the SDRAM controller
  typedef logic [`WB2SDRC_APP_AW-1:0] app_addr_t;

  // Data word, both directions
  typedef logic [`WB2SDRC_DW-1:0] wb_data_t;

  // Byte selects, or active-low byte enables
  typedef logic [`WB2SDRC_SEL_W-1:0] byte_en_t;

  // Burst length field
  typedef logic [`WB2SDRC_BL_W-1:0] burst_len_t;

  // -------------------------------------------------------------------------
  // FIFO payloads
  // -------------------------------------------------------------------------
  // One command entry
  typedef struct packed {
    logic      wr_n;  // 0 write, 1 read
    app_addr_t addr;
  } sdr_cmd_t;

  // One write beat, enables in the upper bits
  typedef struct packed {
    byte_en_t en_n;
    wb_data_t data;
  } sdr_wr_beat_t;

  // -------------------------------------------------------------------------
  // Read tracking
  // -------------------------------------------------------------------------
  // Idle, or a read command issued and its data still outstanding
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_WAIT = 1'b1
  } rd_state_e;

endpackage

// ==== wb2sdrc_macros.svh ====
// Wishbone to SDRAM controller bridge constants
// Bus widths, FIFO depths and the fixed burst length

`ifndef WB2SDRC_MACROS_SVH
`define WB2SDRC_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
// Application address width
`define WB2SDRC_APP_AW 26
// Data width, Wishbone and SDRAM sides alike
`define WB2SDRC_DW 32
// One select bit per byte
`define WB2SDRC_SEL_W (`WB2SDRC_DW / 8)
// Burst-length field width on the request bus
`define WB2SDRC_BL_W 9
// Single transfer per command
`define WB2SDRC_BURST_LEN 1

// ---------------------------------------------------------------------------
// FIFO depths
// ---------------------------------------------------------------------------
`define WB2SDRC_CMD_DEPTH 4
`define WB2SDRC_WRDATA_DEPTH 8
`define WB2SDRC_RDDATA_DEPTH 4

`endif
